/* hdl/soc_defines.svh */
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// ram word address width, 2048 words
`define SOC_ADDR_W 11

// bus data width, matches the ram word
`define SOC_DATA_W 32

// per master request queue depth
// also the credit count a master starts with
`define BUS_CREDITS 2

// keyboard ring sits in the top 16 words of ram
`define KEY_RING_BASE 11'h7f0
`define KEY_RING_WORDS 16

`endif

/* hdl/soc_pkg.sv */
`default_nettype none

`include "soc_defines.svh"

package soc_pkg;

    // ram word address
    typedef logic [`SOC_ADDR_W-1:0] word_addr_t;

    // one bus data word
    typedef logic [`SOC_DATA_W-1:0] bus_word_t;

    // raw ps/2 scan code
    typedef logic [7:0] scan_code_t;

    // sequence tag stored next to each code
    typedef logic [7:0] key_seq_t;

    // ps/2 frame receiver states
    typedef enum logic [1:0] {
        ps2_idle,
        ps2_data,
        ps2_parity,
        ps2_stop
    } ps2_state_t;

endpackage

`default_nettype wire

/* hdl/mem_bus_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface mem_bus_if;

    // request side, driven by the master
    logic                req;
    logic                we;
    soc_pkg::word_addr_t addr;
    soc_pkg::bus_word_t  wdata;

    // one pulse per request taken from the queue
    logic                credit;

    // read data, one cycle after the pop
    logic                rvalid;
    soc_pkg::bus_word_t  rdata;

    modport master (
        output req, we, addr, wdata,
        input  credit, rvalid, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output credit, rvalid, rdata
    );

endinterface

`default_nettype wire

/* hdl/ps2_receiver.sv */
`timescale 1ns/10ps
`default_nettype none

module ps2_receiver (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  ps2_clk,
    input  wire                  ps2_dat,
    output soc_pkg::scan_code_t  code,
    output logic                 code_valid
);

    // two flop synchronizers for the async ps/2 lines
    logic [1:0]           clk_sync;
    logic [1:0]           dat_sync;
    logic                 clk_prev;
    logic                 fall;

    soc_pkg::ps2_state_t  state;
    soc_pkg::scan_code_t  shift;
    logic [2:0]           bit_cnt;
    logic                 parity_bit;
    logic                 frame_ok;

    // lines idle high, so reset the syncs to one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    // device changes data on rising edge, we sample on falling
    assign fall = clk_prev & ~clk_sync[1];

    // odd parity over data plus parity bit, stop bit high
    assign frame_ok = dat_sync[1] & (^{shift, parity_bit});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= soc_pkg::ps2_idle;
            bit_cnt    <= 3'd0;
            code_valid <= 1'b0;
        end else begin
            code_valid <= 1'b0;
            if (fall) begin
                case (state)
                    soc_pkg::ps2_idle: begin
                        // start bit must be low, else stay put
                        if (!dat_sync[1]) begin
                            state   <= soc_pkg::ps2_data;
                            bit_cnt <= 3'd0;
                        end
                    end
                    soc_pkg::ps2_data: begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= soc_pkg::ps2_parity;
                        end
                    end
                    soc_pkg::ps2_parity: begin
                        state <= soc_pkg::ps2_stop;
                    end
                    default: begin
                        state      <= soc_pkg::ps2_idle;
                        code_valid <= frame_ok;
                    end
                endcase
            end
        end
    end

    // payload path, lsb arrives first
    always_ff @(posedge clk) begin
        if (fall) begin
            if (state == soc_pkg::ps2_data) begin
                shift <= {dat_sync[1], shift[7:1]};
            end
            if (state == soc_pkg::ps2_parity) begin
                parity_bit <= dat_sync[1];
            end
            // only good frames update the output code
            if (state == soc_pkg::ps2_stop && frame_ok) begin
                code <= shift;
            end
        end
    end

    // one strobe per frame
    assert property (@(posedge clk) disable iff (!rst_n) code_valid |=> !code_valid)
        else $error("ps2_receiver: code_valid held for more than one cycle");

endmodule

`default_nettype wire

/* hdl/key_capture.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_defines.svh"

module key_capture (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire soc_pkg::scan_code_t code,
    input  wire                  code_valid,
    mem_bus_if.master            bus,
    output logic                 irq,
    input  wire                  irq_ack
);

    localparam int CRED_W = $clog2(`BUS_CREDITS + 1);
    localparam int SLOT_W = $clog2(`KEY_RING_WORDS);

    logic [CRED_W-1:0]    credits;
    logic [SLOT_W-1:0]    slot;
    soc_pkg::key_seq_t    seq;
    logic                 pending;
    soc_pkg::scan_code_t  pend_code;

    // write out as soon as a code waits and a credit is held
    assign bus.req   = pending && (credits != '0);
    assign bus.we    = 1'b1;
    assign bus.addr  = `KEY_RING_BASE + soc_pkg::word_addr_t'(slot);
    // tag in bits 15:8, code in 7:0, upper half zero
    assign bus.wdata = soc_pkg::bus_word_t'({seq, pend_code});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= CRED_W'(`BUS_CREDITS);
            slot    <= '0;
            seq     <= '0;
            pending <= 1'b0;
            irq     <= 1'b0;
        end else begin
            // spend on req, refill on credit pulse
            case ({bus.req, bus.credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase

            // a code arriving while one still waits is dropped
            if (code_valid && (!pending || bus.req)) begin
                pending <= 1'b1;
            end else if (bus.req) begin
                pending <= 1'b0;
            end

            if (bus.req) begin
                // ring wraps after the last slot
                slot <= (slot == SLOT_W'(`KEY_RING_WORDS - 1)) ? '0 : slot + 1'b1;
                seq  <= seq + 1'b1;
            end

            // a new write wins over an ack in the same cycle
            if (bus.req) begin
                irq <= 1'b1;
            end else if (irq_ack) begin
                irq <= 1'b0;
            end
        end
    end

    // code waiting for its ring write
    always_ff @(posedge clk) begin
        if (code_valid && (!pending || bus.req)) begin
            pend_code <= code;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) bus.req |-> credits != '0)
        else $error("key_capture: request issued with no credit");

    // arbiter must never return more credits than were spent
    assert property (@(posedge clk) disable iff (!rst_n)
        bus.credit |-> credits != CRED_W'(`BUS_CREDITS))
        else $error("key_capture: credit returned while already full");

endmodule

`default_nettype wire

/* hdl/bus_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_defines.svh"

module bus_arbiter (
    input  wire                      clk,
    input  wire                      rst_n,
    mem_bus_if.arbiter               cpu_bus,
    mem_bus_if.arbiter               key_bus,
    output logic                     ram_en,
    output logic                     ram_we,
    output soc_pkg::word_addr_t      ram_addr,
    output soc_pkg::bus_word_t       ram_wdata,
    input  wire soc_pkg::bus_word_t  ram_rdata
);

    // queue entry is {we, addr, wdata}
    localparam int ENTRY_W = 1 + `SOC_ADDR_W + `SOC_DATA_W;
    localparam int PTR_W   = ($clog2(`BUS_CREDITS) > 0) ? $clog2(`BUS_CREDITS) : 1;
    localparam int CNT_W   = $clog2(`BUS_CREDITS + 1);

    // index 0 is the processor, index 1 the keyboard
    logic [ENTRY_W-1:0]  q_mem [2][`BUS_CREDITS];
    logic [PTR_W-1:0]    wr_ptr [2];
    logic [PTR_W-1:0]    rd_ptr [2];
    logic [CNT_W-1:0]    count [2];

    logic [1:0]          push;
    logic [ENTRY_W-1:0]  push_entry [2];
    logic [1:0]          has;
    logic [1:0]          pop;
    logic                pop_valid;
    logic                pop_sel;
    logic                prefer;
    logic [ENTRY_W-1:0]  head;
    logic                head_we;

    // read return tracking
    logic                rd_pend;
    logic                rd_tag;

    // reads taken in from each master but not yet answered
    logic [CNT_W:0]      rd_out [2];
    logic [1:0]          push_rd;
    logic [1:0]          resp;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`BUS_CREDITS - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push[0]       = cpu_bus.req;
    assign push[1]       = key_bus.req;
    assign push_entry[0] = {cpu_bus.we, cpu_bus.addr, cpu_bus.wdata};
    assign push_entry[1] = {key_bus.we, key_bus.addr, key_bus.wdata};

    assign has[0] = (count[0] != '0);
    assign has[1] = (count[1] != '0);

    // round robin only matters when both queues hold work
    always_comb begin
        pop_valid = has[0] | has[1];
        if (has[0] && has[1]) begin
            pop_sel = prefer;
        end else begin
            pop_sel = has[1];
        end
    end

    assign pop[0] = pop_valid & ~pop_sel;
    assign pop[1] = pop_valid & pop_sel;

    assign head    = q_mem[pop_sel][rd_ptr[pop_sel]];
    assign head_we = head[ENTRY_W-1];

    // queue head goes straight to the ram
    assign ram_en    = pop_valid;
    assign ram_we    = pop_valid & head_we;
    assign ram_addr  = head[ENTRY_W-2 -: `SOC_ADDR_W];
    assign ram_wdata = head[`SOC_DATA_W-1:0];

    // credit back in the cycle of the pop
    assign cpu_bus.credit = pop[0];
    assign key_bus.credit = pop[1];

    // ram data shows up one cycle later and is steered by tag
    assign cpu_bus.rvalid = rd_pend & ~rd_tag;
    assign key_bus.rvalid = rd_pend & rd_tag;
    assign cpu_bus.rdata  = ram_rdata;
    assign key_bus.rdata  = ram_rdata;

    // read requests as they enter, responses as they leave
    assign push_rd[0] = cpu_bus.req & ~cpu_bus.we;
    assign push_rd[1] = key_bus.req & ~key_bus.we;
    assign resp[0]    = cpu_bus.rvalid;
    assign resp[1]    = key_bus.rvalid;

    // queue storage
    always_ff @(posedge clk) begin
        for (int m = 0; m < 2; m++) begin
            if (push[m]) begin
                q_mem[m][wr_ptr[m]] <= push_entry[m];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int m = 0; m < 2; m++) begin
                wr_ptr[m] <= '0;
                rd_ptr[m] <= '0;
                count[m]  <= '0;
                rd_out[m] <= '0;
            end
            prefer  <= 1'b0;
            rd_pend <= 1'b0;
            rd_tag  <= 1'b0;
        end else begin
            for (int m = 0; m < 2; m++) begin
                if (push[m]) begin
                    wr_ptr[m] <= next_ptr(wr_ptr[m]);
                end
                if (pop[m]) begin
                    rd_ptr[m] <= next_ptr(rd_ptr[m]);
                end
                if (push[m] && !pop[m]) begin
                    count[m] <= count[m] + 1'b1;
                end else if (!push[m] && pop[m]) begin
                    count[m] <= count[m] - 1'b1;
                end
                if (push_rd[m] && !resp[m]) begin
                    rd_out[m] <= rd_out[m] + 1'b1;
                end else if (!push_rd[m] && resp[m]) begin
                    rd_out[m] <= rd_out[m] - 1'b1;
                end
            end
            // other master gets first pick next time
            if (pop_valid) begin
                prefer <= ~pop_sel;
                rd_tag <= pop_sel;
            end
            rd_pend <= pop_valid & ~head_we;
        end
    end

    // masters obey their credit count, so a full queue never sees a push
    for (genvar m = 0; m < 2; m++) begin : g_chk
        assert property (@(posedge clk) disable iff (!rst_n)
            push[m] |-> count[m] != CNT_W'(`BUS_CREDITS))
            else $error("bus_arbiter: push into full queue %0d", m);

        // every response answers a read this master handed in earlier
        assert property (@(posedge clk) disable iff (!rst_n)
            resp[m] |-> rd_out[m] != '0)
            else $error("bus_arbiter: read response to master %0d with no read outstanding", m);
    end

endmodule

`default_nettype wire

/* hdl/shared_ram.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_defines.svh"

module shared_ram (
    input  wire                      clk,
    input  wire                      en,
    input  wire                      we,
    input  wire soc_pkg::word_addr_t addr,
    input  wire soc_pkg::bus_word_t  wdata,
    output soc_pkg::bus_word_t       rdata
);

    localparam int DEPTH = 2 ** `SOC_ADDR_W;

    // inferred block ram
    soc_pkg::bus_word_t mem [DEPTH];

    // start from a clean memory image
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // single port, write or read per cycle
    // read data registered, valid the next cycle
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/board_soc.sv */
`timescale 1ns/10ps
`default_nettype none

module board_soc (
    input  wire                      CLOCK_50,
    input  wire                      KEY0,
    input  wire                      cpu_req,
    input  wire                      cpu_we,
    input  wire soc_pkg::word_addr_t cpu_addr,
    input  wire soc_pkg::bus_word_t  cpu_wdata,
    output logic                     cpu_credit,
    output logic                     cpu_rvalid,
    output soc_pkg::bus_word_t       cpu_rdata,
    input  wire                      PS2_CLK,
    input  wire                      PS2_DAT,
    output logic                     key_irq,
    input  wire                      key_irq_ack
);

    // one bus per master
    mem_bus_if cpu_bus ();
    mem_bus_if key_bus ();

    soc_pkg::scan_code_t key_code;
    logic                key_code_valid;

    logic                ram_en;
    logic                ram_we;
    soc_pkg::word_addr_t ram_addr;
    soc_pkg::bus_word_t  ram_wdata;
    soc_pkg::bus_word_t  ram_rdata;

    // processor pins onto its bus
    assign cpu_bus.req   = cpu_req;
    assign cpu_bus.we    = cpu_we;
    assign cpu_bus.addr  = cpu_addr;
    assign cpu_bus.wdata = cpu_wdata;
    assign cpu_credit    = cpu_bus.credit;
    assign cpu_rvalid    = cpu_bus.rvalid;
    assign cpu_rdata     = cpu_bus.rdata;

    ps2_receiver u_ps2 (
        .clk        (CLOCK_50),
        .rst_n      (KEY0),
        .ps2_clk    (PS2_CLK),
        .ps2_dat    (PS2_DAT),
        .code       (key_code),
        .code_valid (key_code_valid)
    );

    // keyboard is a second bus master
    key_capture u_key (
        .clk        (CLOCK_50),
        .rst_n      (KEY0),
        .code       (key_code),
        .code_valid (key_code_valid),
        .bus        (key_bus.master),
        .irq        (key_irq),
        .irq_ack    (key_irq_ack)
    );

    bus_arbiter u_arb (
        .clk       (CLOCK_50),
        .rst_n     (KEY0),
        .cpu_bus   (cpu_bus.arbiter),
        .key_bus   (key_bus.arbiter),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    shared_ram u_ram (
        .clk   (CLOCK_50),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

/* sim/board_soc_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_defines.svh"

module board_soc_tb;

    localparam int    RAM_WORDS       = 2 ** `SOC_ADDR_W;
    // ps/2 half period in system clocks
    localparam int    PS2_HALF        = 8;
    localparam int    CYCLES_PER_LINE = 2000;
    localparam string PATTERN_FILE    = "sim/board_soc_patterns.txt";

    logic                CLOCK_50;
    logic                KEY0;
    logic                cpu_req;
    logic                cpu_we;
    soc_pkg::word_addr_t cpu_addr;
    soc_pkg::bus_word_t  cpu_wdata;
    logic                cpu_credit;
    logic                cpu_rvalid;
    soc_pkg::bus_word_t  cpu_rdata;
    logic                PS2_CLK;
    logic                PS2_DAT;
    logic                key_irq;
    logic                key_irq_ack;

    // processor model
    int                  credits;
    soc_pkg::bus_word_t  exp_q [$];
    soc_pkg::bus_word_t  ram_model [RAM_WORDS];
    logic [31:0]         rng;
    int                  watchdog_cycles;

    board_soc UUT (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .cpu_req     (cpu_req),
        .cpu_we      (cpu_we),
        .cpu_addr    (cpu_addr),
        .cpu_wdata   (cpu_wdata),
        .cpu_credit  (cpu_credit),
        .cpu_rvalid  (cpu_rvalid),
        .cpu_rdata   (cpu_rdata),
        .PS2_CLK     (PS2_CLK),
        .PS2_DAT     (PS2_DAT),
        .key_irq     (key_irq),
        .key_irq_ack (key_irq_ack)
    );

    // 40 ns period
    initial begin
        CLOCK_50 = 1'b0;
        forever #20 CLOCK_50 = ~CLOCK_50;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s got %h expected %h",
                               $time, name, got, exp));
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // inputs move 2 ns after the rising edge
    task automatic step();
        @(posedge CLOCK_50);
        #2;
    endtask

    // one request once a credit is free
    task automatic issue(input logic we, input soc_pkg::word_addr_t addr,
                         input soc_pkg::bus_word_t data, input soc_pkg::bus_word_t exp);
        while (credits == 0) begin
            step();
        end
        cpu_req   = 1'b1;
        cpu_we    = we;
        cpu_addr  = addr;
        cpu_wdata = data;
        credits   = credits - 1;
        if (!we) begin
            exp_q.push_back(exp);
        end
        step();
        cpu_req = 1'b0;
    endtask

    // wait for all credits home and all reads answered
    task automatic drain();
        while (credits != `BUS_CREDITS || exp_q.size() != 0) begin
            step();
        end
    endtask

    task automatic send_frame(input soc_pkg::scan_code_t code, input logic good);
        logic [10:0] bits;
        logic        par;
        // odd parity flipped for a bad frame
        par  = good ? ~^code : ^code;
        bits = {1'b1, par, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            // data changes while the ps/2 clock is high
            PS2_DAT = bits[i];
            repeat (PS2_HALF) step();
            PS2_CLK = 1'b0;
            repeat (PS2_HALF) step();
            PS2_CLK = 1'b1;
        end
        PS2_DAT = 1'b1;
        // idle gap long enough for the ring write
        repeat (2 * PS2_HALF) step();
    endtask

    task automatic run_burst(input int count);
        soc_pkg::word_addr_t addr;
        soc_pkg::bus_word_t  data;
        logic                we;
        for (int i = 0; i < count; i++) begin
            rng  = xorshift(rng);
            we   = rng[0];
            // small window so reads hit earlier writes and stay clear of the ring
            addr = soc_pkg::word_addr_t'(rng[13:8]);
            rng  = xorshift(rng);
            data = rng;
            if (we) begin
                ram_model[addr] = data;
                issue(1'b1, addr, data, '0);
            end else begin
                issue(1'b0, addr, '0, ram_model[addr]);
            end
        end
        drain();
    endtask

    // outputs are settled by the falling edge
    always @(negedge CLOCK_50) begin
        if (KEY0 === 1'b1) begin
            if (cpu_credit) begin
                if (credits >= `BUS_CREDITS) begin
                    fail_run("credit returned while no processor request was outstanding");
                end else begin
                    credits = credits + 1;
                end
            end
            if (cpu_rvalid) begin
                if (exp_q.size() == 0) begin
                    fail_run("read data returned with no processor read outstanding");
                end else begin
                    check_value("cpu_rdata", cpu_rdata, exp_q.pop_front());
                end
            end
        end
    end

    // budget scales with the pattern file length
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge CLOCK_50);
        fail_run("watchdog expired before the pattern file was finished");
    end

    initial begin
        int              fd;
        int              n;
        int              lines;
        string           line;
        logic [8*12-1:0] cmd;
        logic [8*8-1:0]  word;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     c;

        KEY0            = 1'b0;
        cpu_req         = 1'b0;
        cpu_we          = 1'b0;
        cpu_addr        = '0;
        cpu_wdata       = '0;
        PS2_CLK         = 1'b1;
        PS2_DAT         = 1'b1;
        key_irq_ack     = 1'b0;
        credits         = `BUS_CREDITS;
        rng             = 32'h9c8a;
        watchdog_cycles = 0;
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram_model[i] = '0;
        end

        // first pass only counts lines
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            fail_run("cannot open the pattern file");
        end
        lines = 0;
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0) begin
                lines = lines + 1;
            end
        end
        $fclose(fd);
        watchdog_cycles = (lines + 1) * CYCLES_PER_LINE;

        repeat (4) @(posedge CLOCK_50);
        #2;
        KEY0 = 1'b1;
        step();

        fd = $fopen(PATTERN_FILE, "r");
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            // skip blank and comment lines
            if (n > 1 && line.getc(0) != 8'h23) begin
                n = $sscanf(line, "%s", cmd);
                if (cmd == "write") begin
                    n = $sscanf(line, "%s %h %h", cmd, a, b);
                    ram_model[a[`SOC_ADDR_W-1:0]] = b;
                    issue(1'b1, a[`SOC_ADDR_W-1:0], b, '0);
                    drain();
                end else if (cmd == "read") begin
                    n = $sscanf(line, "%s %h %h", cmd, a, b);
                    issue(1'b0, a[`SOC_ADDR_W-1:0], '0, b);
                    drain();
                end else if (cmd == "key") begin
                    n = $sscanf(line, "%s %h %s", cmd, a, word);
                    send_frame(a[7:0], word == "good");
                end else if (cmd == "irq") begin
                    n = $sscanf(line, "%s %d", cmd, a);
                    @(negedge CLOCK_50);
                    check_value("key_irq", {31'b0, key_irq}, a);
                    step();
                end else if (cmd == "ack") begin
                    key_irq_ack = 1'b1;
                    step();
                    key_irq_ack = 1'b0;
                    step();
                end else if (cmd == "burst") begin
                    n = $sscanf(line, "%s %d %h", cmd, a, b);
                    // zero seed keeps the running sequence
                    if (b != 0) begin
                        rng = b;
                    end
                    run_burst(a);
                end else if (cmd == "burst_key") begin
                    n = $sscanf(line, "%s %d %h %h", cmd, a, b, c);
                    if (b != 0) begin
                        rng = b;
                    end
                    fork
                        begin
                            // burst starts mid frame so the ring write lands inside it
                            repeat (11 * PS2_HALF) step();
                            run_burst(a);
                        end
                        send_frame(c[7:0], 1'b1);
                    join
                end else begin
                    fail_run({"unknown command in pattern file: ", line});
                end
            end
        end
        $fclose(fd);
        drain();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/board_soc_patterns.txt */
# columns: command arg1 arg2 [arg3]; addr, data, code and seed in hex, count and level in decimal
# write addr data | read addr expected | key code good/bad | irq level | ack | burst count seed | burst_key count seed code
write 005 a5a50001
write 02a 12345678
write 3ff deadbeef
write 100 0badf00d
read 005 a5a50001
read 02a 12345678
read 3ff deadbeef
read 100 0badf00d
read 200 00000000
burst 100 9c8a
key 1c good
irq 1
read 7f0 0000001c
ack
irq 0
key 32 good
irq 1
read 7f1 00000132
ack
irq 0
key 5a bad
irq 0
read 7f2 00000000
key 21 good
irq 1
read 7f2 00000221
key 23 good
key 2b good
key 34 good
key 33 good
key 43 good
key 3b good
key 42 good
key 4b good
key 3a good
key 31 good
key 44 good
key 4d good
key 15 good
key 1d good
read 7f0 0000101d
read 7f1 00000132
read 7ff 00000f15
ack
irq 0
burst_key 160 0 2d
irq 1
read 7f1 0000112d
read 100 0badf00d
ack
irq 0

/* board_soc.f */
+incdir+hdl
hdl/soc_pkg.sv
hdl/mem_bus_if.sv
hdl/ps2_receiver.sv
hdl/key_capture.sv
hdl/bus_arbiter.sv
hdl/shared_ram.sv
hdl/board_soc.sv
sim/board_soc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the board_soc testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module board_soc_tb -Mdir obj_dir -f board_soc.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vboard_soc_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
if ! grep -q "TESTS PASSED" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
